// File: logic/pdp8_pkg.sv
// PDP-8 shared types: word width, instruction formats, opcodes, handshake payloads
`default_nettype none

package pdp8_pkg;

	parameter int WORD_W   = 12;                 // Machine word
	parameter int PAGE_W   = 5;                  // Page number bits of an address
	parameter int OFFSET_W = 7;                  // Word offset within a page
	parameter int MICRO_W  = 8;                  // Microinstruction field of OPR

	typedef logic [WORD_W-1:0] word_t;           // Memory word or register

	typedef enum logic [2:0] {
		OP_AND = 3'd0,                           // AC and operand
		OP_TAD = 3'd1,                           // Two's complement add
		OP_ISZ = 3'd2,                           // Increment, skip on zero
		OP_DCA = 3'd3,                           // Deposit and clear AC
		OP_JMS = 3'd4,                           // Jump to subroutine
		OP_JMP = 3'd5,                           // Jump
		OP_IOT = 3'd6,                           // Device I/O, runs as no-op here
		OP_OPR = 3'd7                            // Operate microinstructions
	} opcode_e;

	// Memory-reference view, bit 0 of the PDP-8 numbering is the MSB
	typedef struct packed {
		opcode_e               opcode;
		logic                  indirect;         // I bit
		logic                  current_page;     // M bit, else page zero
		logic [OFFSET_W-1:0]   offset;
	} mem_ref_fmt_t;

	// Operate view
	typedef struct packed {
		opcode_e               opcode;
		logic                  group;            // 0 group 1, 1 group 2 or 3
		logic [MICRO_W-1:0]    micro;
	} operate_fmt_t;

	// Instruction register, decoded both ways
	typedef union packed {
		mem_ref_fmt_t mem_ref;
		operate_fmt_t operate;
	} instr_u;

	// Group 1 bit positions in micro
	parameter int G1_CLA   = 7;
	parameter int G1_CLL   = 6;
	parameter int G1_CMA   = 5;
	parameter int G1_CML   = 4;
	parameter int G1_RAR   = 3;
	parameter int G1_RAL   = 2;
	parameter int G1_TWICE = 1;                  // Rotate by two
	parameter int G1_IAC   = 0;

	// Group 2 bit positions in micro
	parameter int G2_CLA   = 7;
	parameter int G2_SMA   = 6;
	parameter int G2_SZA   = 5;
	parameter int G2_SNL   = 4;
	parameter int G2_REV   = 3;                  // Reverse sense, AND subgroup
	parameter int G2_OSR   = 2;
	parameter int G2_HLT   = 1;
	parameter int G2_GRP3  = 0;                  // Set for group 3 words

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic  we;                               // Write, else read
	} mem_req_t;

	typedef struct packed {
		word_t addr;
		word_t data;
	} load_word_t;

endpackage

`default_nettype wire

// File: logic/pdp8_operate.sv
// PDP-8 operate unit: combinational group 1 and group 2 microinstruction evaluation
`default_nettype none

module pdp8_operate (
	input  wire pdp8_pkg::instr_u i_instr,
	input  wire pdp8_pkg::word_t  i_ac,
	input  wire logic             i_link,
	input  wire pdp8_pkg::word_t  i_sr,
	output pdp8_pkg::word_t       o_ac,
	output logic                  o_link,
	output logic                  o_skip,
	output logic                  o_halt
);
	import pdp8_pkg::*;

	operate_fmt_t       op;                              // Operate view of the word
	logic [MICRO_W-1:0] m;                               // Microinstruction bits

	assign op = i_instr.operate;
	assign m  = op.micro;

	always_comb begin
		word_t ac;
		logic  link;
		logic  any_cond;                                 // Some selected skip condition holds

		ac       = i_ac;
		link     = i_link;
		any_cond = 1'b0;
		o_skip   = 1'b0;
		o_halt   = 1'b0;

		if (!op.group) begin
			// Group 1, steps in sequence
			if (m[G1_CLA])
				ac = '0;
			if (m[G1_CLL])
				link = 1'b0;
			if (m[G1_CMA])
				ac = ~ac;
			if (m[G1_CML])
				link = ~link;
			if (m[G1_IAC])
				{link, ac} = {link, ac} + (WORD_W+1)'(1);  // Carry flips link
			case ({m[G1_RAR], m[G1_RAL]})
				2'b10: begin                             // Right through link
					if (m[G1_TWICE])
						{link, ac} = {ac[1:0], link, ac[WORD_W-1:2]};
					else
						{link, ac} = {ac[0], link, ac[WORD_W-1:1]};
				end
				2'b01: begin                             // Left through link
					if (m[G1_TWICE])
						{link, ac} = {ac[WORD_W-2:0], link, ac[WORD_W-1]};
					else
						{link, ac} = {ac, link};
				end
				default: ;                               // None, or both set
			endcase
		end else if (!m[G2_GRP3]) begin
			// Group 2, skip tested on the incoming AC and link
			any_cond = (m[G2_SMA] && ac[WORD_W-1])
				|| (m[G2_SZA] && (ac == '0))
				|| (m[G2_SNL] && link);
			o_skip = m[G2_REV] ? !any_cond : any_cond;  // Reverse with none selected is SKP
			if (m[G2_CLA])
				ac = '0;
			if (m[G2_OSR])
				ac = ac | i_sr;
			o_halt = m[G2_HLT];
		end
		// Group 3 falls through unchanged

		o_ac   = ac;
		o_link = link;
	end

endmodule

`default_nettype wire

// File: logic/pdp8_control.sv
// PDP-8 control unit with run handshake and fetch, defer and execute sequencing of PC, AC and link
`default_nettype none

module pdp8_control (
	input  wire logic               i_clk,
	input  wire logic               i_rst_n,
	input  wire logic               i_run_req,
	input  wire pdp8_pkg::word_t    i_start_pc,
	input  wire pdp8_pkg::word_t    i_sr,
	output logic                    o_run_ack,
	output pdp8_pkg::word_t         o_ac,
	output logic                    o_link,
	output pdp8_pkg::word_t         o_pc,
	output pdp8_pkg::mem_req_t      o_mem_req,
	output logic                    o_mem_req_valid,
	input  wire pdp8_pkg::word_t    i_mem_rdata,
	input  wire logic               i_mem_ack
);
	import pdp8_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_DEFER,
		S_EXEC_RD,
		S_EXEC_WR,
		S_HALTED
	} state_e;

	state_e  state;
	logic    req_valid;                                  // Memory request out
	logic    acc_done;                                   // Access data latched and ready to process
	logic    run_ack;
	word_t   pc;                                         // Instruction address until processed
	word_t   ac;
	logic    link;
	instr_u  ir;
	word_t   mb;                                         // Memory buffer
	word_t   ea;                                         // Pointer, then final operand address
	word_t   sr;                                         // Switch register for this run
	opcode_e opcode;
	word_t   eff_addr;                                   // Page zero or current page address
	word_t   pc_inc;
	logic    latch;                                      // Ack seen on own request
	logic    direct_write;                               // No operand read needed
	word_t   op_ac;
	logic    op_link;
	logic    op_skip;
	logic    op_halt;

	assign opcode       = ir.mem_ref.opcode;
	assign pc_inc       = pc + word_t'(1);
	assign eff_addr     = {pc[WORD_W-1:OFFSET_W] & {PAGE_W{ir.mem_ref.current_page}},
		ir.mem_ref.offset};
	assign latch        = !acc_done && req_valid && i_mem_ack;
	assign direct_write = (opcode == OP_DCA) || (opcode == OP_JMS);

	assign o_run_ack       = run_ack;
	assign o_ac            = ac;
	assign o_link          = link;
	assign o_pc            = pc;
	assign o_mem_req_valid = req_valid;

	// Request payload follows the state and holds while waiting for ack
	always_comb begin
		o_mem_req.addr = (state == S_FETCH) ? pc : ea;
		o_mem_req.we   = (state == S_EXEC_WR);
		case (opcode)
			OP_DCA:  o_mem_req.wdata = ac;
			OP_JMS:  o_mem_req.wdata = pc;               // Already the return address
			default: o_mem_req.wdata = mb;               // ISZ result
		endcase
	end

	pdp8_operate u_operate (
		.i_instr (ir),
		.i_ac    (ac),
		.i_link  (link),
		.i_sr    (sr),
		.o_ac    (op_ac),
		.o_link  (op_link),
		.o_skip  (op_skip),
		.o_halt  (op_halt)
	);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= S_IDLE;
			req_valid <= 1'b0;
			acc_done  <= 1'b0;
			run_ack   <= 1'b0;
			pc        <= '0;
			ac        <= '0;
			link      <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (i_run_req) begin
						pc    <= i_start_pc;
						ac    <= '0;                     // Each run starts clean
						link  <= 1'b0;
						state <= S_FETCH;
					end
				end
				S_HALTED: begin
					if (!i_run_req) begin
						run_ack <= 1'b0;                 // Falls one cycle after req
						state   <= S_IDLE;
					end
				end
				default: begin
					if (!acc_done) begin
						if (!req_valid && !i_mem_ack)
							req_valid <= 1'b1;           // New access once the previous ack is gone
						else if (latch) begin
							req_valid <= 1'b0;
							acc_done  <= 1'b1;
						end
					end else begin
						acc_done <= 1'b0;                // Overlaps the ack falling
						case (state)
							S_FETCH: begin
								if (opcode == OP_OPR) begin
									ac   <= op_ac;
									link <= op_link;
									if (op_halt) begin
										run_ack <= 1'b1;   // PC stays on the HLT
										state   <= S_HALTED;
									end else
										pc <= pc + (op_skip ? word_t'(2) : word_t'(1));
								end else if (opcode == OP_IOT)
									pc <= pc_inc;
								else begin
									pc <= pc_inc;
									if (ir.mem_ref.indirect)
										state <= S_DEFER;
									else if (opcode == OP_JMP)
										pc <= eff_addr;
									else
										state <= direct_write ? S_EXEC_WR : S_EXEC_RD;
								end
							end
							S_DEFER: begin
								if (opcode == OP_JMP) begin
									pc    <= mb;
									state <= S_FETCH;
								end else
									state <= direct_write ? S_EXEC_WR : S_EXEC_RD;
							end
							S_EXEC_RD: begin
								case (opcode)
									OP_AND: begin
										ac    <= ac & mb;
										state <= S_FETCH;
									end
									OP_TAD: begin
										{link, ac} <= {link, ac} + {1'b0, mb};
										state      <= S_FETCH;
									end
									default: state <= S_EXEC_WR;   // ISZ writes back
								endcase
							end
							S_EXEC_WR: begin
								case (opcode)
									OP_DCA: ac <= '0;
									OP_JMS: pc <= ea + word_t'(1);
									default: begin
										if (mb == '0)
											pc <= pc_inc;          // ISZ skip
									end
								endcase
								state <= S_FETCH;
							end
							default: state <= S_IDLE;
						endcase
					end
				end
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge i_clk) begin
		if (state == S_IDLE && i_run_req)
			sr <= i_sr;
		if (latch && state == S_FETCH)
			ir <= i_mem_rdata;
		if (latch && (state == S_DEFER || state == S_EXEC_RD))
			mb <= i_mem_rdata;                           // Pointer or operand
		else if (acc_done && state == S_EXEC_RD)
			mb <= mb + word_t'(1);                       // Only ISZ goes on to use it
		if (acc_done && state == S_FETCH)
			ea <= eff_addr;
		else if (acc_done && state == S_DEFER)
			ea <= mb;                                    // Follow the pointer
	end

	// Run ack answers a pending run request
	a_ack_after_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(o_run_ack) |-> $past(i_run_req));

endmodule

`default_nettype wire

// File: logic/pdp8_memory.sv
// PDP-8 core memory with a processor port and a program load port, both four-phase
`default_nettype none

module pdp8_memory #(
	parameter int MEM_DEPTH = 4096                       // Power of two, at most 4096
) (
	input  wire logic                 i_clk,
	input  wire logic                 i_rst_n,
	input  wire pdp8_pkg::mem_req_t   i_mem_req,
	input  wire logic                 i_mem_req_valid,
	output pdp8_pkg::word_t           o_mem_rdata,
	output logic                      o_mem_ack,
	input  wire pdp8_pkg::load_word_t i_load,
	input  wire logic                 i_load_req,
	output logic                      o_load_ack
);
	import pdp8_pkg::*;

	localparam int ADDR_W = $clog2(MEM_DEPTH);           // Upper address bits ignored

	word_t mem [MEM_DEPTH];                              // Core array
	logic  mem_take;                                     // Processor access this cycle
	logic  load_take;                                    // Load write this cycle

	// Processor port has priority, a load waits for an idle processor port
	assign mem_take  = i_mem_req_valid && !o_mem_ack && !o_load_ack;
	assign load_take = i_load_req && !o_load_ack && !o_mem_ack && !i_mem_req_valid;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_mem_ack  <= 1'b0;
			o_load_ack <= 1'b0;
		end else begin
			if (mem_take)
				o_mem_ack <= 1'b1;                       // Ack one cycle after req
			else if (o_mem_ack && !i_mem_req_valid)
				o_mem_ack <= 1'b0;                       // Release after req drops
			if (load_take)
				o_load_ack <= 1'b1;
			else if (o_load_ack && !i_load_req)
				o_load_ack <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (mem_take) begin
			o_mem_rdata <= mem[i_mem_req.addr[ADDR_W-1:0]];  // Old contents on a write
			if (i_mem_req.we)
				mem[i_mem_req.addr[ADDR_W-1:0]] <= i_mem_req.wdata;
		end
		if (load_take)
			mem[i_load.addr[ADDR_W-1:0]] <= i_load.data;
	end

	// Requester must hold the payload until the ack arrives
	a_req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_mem_req_valid && !o_mem_ack) |=> $stable(i_mem_req));

	// Only one port served at a time
	a_one_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_mem_ack && o_load_ack));

endmodule

`default_nettype wire

// File: logic/pdp8_top.sv
// PDP-8 processor top: control with operate unit, and core memory
`default_nettype none

module pdp8_top #(
	parameter int MEM_DEPTH = 4096                       // Words of core
) (
	input  wire logic                 i_clk,
	input  wire logic                 i_rst_n,
	input  wire pdp8_pkg::load_word_t i_load,
	input  wire logic                 i_load_req,
	output logic                      o_load_ack,
	input  wire logic                 i_run_req,
	input  wire pdp8_pkg::word_t      i_start_pc,
	input  wire pdp8_pkg::word_t      i_sr,
	output logic                      o_run_ack,
	output pdp8_pkg::word_t           o_ac,
	output logic                      o_link,
	output pdp8_pkg::word_t           o_pc
);
	import pdp8_pkg::*;

	mem_req_t mem_req;                                   // Control to memory
	logic     mem_req_valid;
	word_t    mem_rdata;
	logic     mem_ack;

	pdp8_control u_control (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_run_req       (i_run_req),
		.i_start_pc      (i_start_pc),
		.i_sr            (i_sr),
		.o_run_ack       (o_run_ack),
		.o_ac            (o_ac),
		.o_link          (o_link),
		.o_pc            (o_pc),
		.o_mem_req       (mem_req),
		.o_mem_req_valid (mem_req_valid),
		.i_mem_rdata     (mem_rdata),
		.i_mem_ack       (mem_ack)
	);

	pdp8_memory #(
		.MEM_DEPTH (MEM_DEPTH)
	) u_memory (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_mem_req       (mem_req),
		.i_mem_req_valid (mem_req_valid),
		.o_mem_rdata     (mem_rdata),
		.o_mem_ack       (mem_ack),
		.i_load          (i_load),
		.i_load_req      (i_load_req),
		.o_load_ack      (o_load_ack)
	);

endmodule

`default_nettype wire

// File: verification/pdp8_clock_gen.sv
// Testbench clock source, free running with a 100 ns period
`default_nettype none

module pdp8_clock_gen #(
	parameter int PERIOD_NS = 100                        // Full clock period
) (
	output logic o_clk
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		o_clk = 1'b0;                                    // Starts low, first rise at half period
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

endmodule

`default_nettype wire

// File: verification/pdp8_tb_programs.svh
// PDP-8 test programs: load words in octal, start address, switches and expected results
`ifndef PDP8_TB_PROGRAMS_SVH
`define PDP8_TB_PROGRAMS_SVH

	typedef struct packed {
		int    first;                                    // First entry in LOAD_TABLE
		int    count;                                    // Number of load words, 16 at most
		word_t start_pc;
		word_t sr;                                       // Switch register
		word_t exp_ac;
		logic  exp_link;
		word_t exp_pc;                                   // Address of the HLT
	} test_t;

	localparam int NUM_TESTS  = 6;
	localparam int NUM_WORDS  = 55;
	localparam int RAND_TEST  = 1;                       // Operands replaced by random values
	localparam int RAND_A_IDX = 10;                      // Page zero operand of that test
	localparam int RAND_B_IDX = 14;                      // Current page operand of that test

	// Each entry is address then data, both four octal digits
	localparam load_word_t LOAD_TABLE [NUM_WORDS] = '{
		// TAD page zero and current page, AND, DCA then read back
		24'o0150_3456, 24'o0400_1150, 24'o0401_1260, 24'o0402_0261, 24'o0403_3262,
		24'o0404_1262, 24'o0405_7402, 24'o0460_5432, 24'o0461_7070, 24'o0462_0000,
		// Random pair, 13 bit sum
		24'o0151_0000, 24'o0600_1151, 24'o0601_1210, 24'o0602_7402, 24'o0610_0000,
		// JMP to JMS I, subroutine returns by JMP I on its entry word
		24'o0152_1020, 24'o1000_4552, 24'o1001_1230, 24'o1002_7402, 24'o1003_5200,
		24'o1020_0000, 24'o1021_1231, 24'o1022_5620, 24'o1030_0100, 24'o1031_0023,
		// ISZ loop, counter preset to minus 3
		24'o1200_7001, 24'o1201_2210, 24'o1202_5200, 24'o1203_7402, 24'o1210_7775,
		// CLA CLL CMA IAC, RAL, RTL, TAD, RAR, RTR, CML with both rotate bits
		24'o1400_7341, 24'o1401_7004, 24'o1402_7006, 24'o1403_1220, 24'o1404_7010,
		24'o1405_7012, 24'o1406_7034, 24'o1407_7402, 24'o1420_4001,
		// SZA, SMA SNL, SNA, SKP, OSR, SPA, each steering which TAD lands
		24'o1600_7440, 24'o1601_1240, 24'o1602_1241, 24'o1603_7520, 24'o1604_1242,
		24'o1605_7450, 24'o1606_1240, 24'o1607_7410, 24'o1610_1240, 24'o1611_7404,
		24'o1612_7510, 24'o1613_1241, 24'o1614_7402, 24'o1640_0001, 24'o1641_0002,
		24'o1642_0004
	};

	// first, count, start PC, SR, AC, link, HLT address
	localparam test_t TESTS [NUM_TESTS] = '{
		'{0,  10, 12'o0400, 12'o0000, 12'o1010, 1'b1, 12'o0405},
		'{10, 5,  12'o0600, 12'o0000, 12'o0000, 1'b0, 12'o0602},   // AC, link worked out at run
		'{15, 10, 12'o1003, 12'o0000, 12'o0123, 1'b0, 12'o1002},
		'{25, 5,  12'o1200, 12'o0000, 12'o0003, 1'b0, 12'o1203},
		'{30, 9,  12'o1400, 12'o0000, 12'o2400, 1'b0, 12'o1407},
		'{39, 16, 12'o1600, 12'o5000, 12'o5010, 1'b0, 12'o1614}
	};

`endif

// File: verification/pdp8_tb.sv
// PDP-8 processor testbench: loads each program, runs it to HLT and checks AC, link and PC
`default_nettype none

module pdp8_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import pdp8_pkg::*;

	`include "pdp8_tb_programs.svh"

	localparam int DRIVE_DELAY    = 10;                  // After the rising edge
	localparam int RESET_CYCLES   = 8;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * (16 * 4 + 16 * 16) + 100;

	logic       clk;
	logic       rst_n;
	load_word_t load;
	logic       load_req;
	logic       load_ack;
	logic       run_req;
	word_t      start_pc;
	word_t      sr;
	logic       run_ack;
	word_t      ac;
	logic       link;
	word_t      pc;

	load_word_t words [NUM_WORDS];                       // Table copy, random operands patched in
	integer     seed;
	word_t      rand_a;
	word_t      rand_b;
	int         errors;
	int         checks;
	int         cycles;
	string      phase;                                   // Handshake being waited on

	pdp8_clock_gen u_clk_gen (
		.o_clk (clk)
	);

	pdp8_top #(
		.MEM_DEPTH (4096)
	) u_dut (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_load     (load),
		.i_load_req (load_req),
		.o_load_ack (load_ack),
		.i_run_req  (run_req),
		.i_start_pc (start_pc),
		.i_sr       (sr),
		.o_run_ack  (run_ack),
		.o_ac       (ac),
		.o_link     (link),
		.o_pc       (pc)
	);

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;                                    // Outputs settled, safe to drive
	endtask

	task automatic check_value(input string where, input string name,
		input word_t expected, input word_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch %s in %s: expected %h, actual %h", name, where, expected, actual);
		end
	endtask

	task automatic load_word(input load_word_t lw);
		load     = lw;
		load_req = 1'b1;
		phase    = "o_load_ack to rise";
		while (!load_ack)
			next_cycle();
		load_req = 1'b0;
		phase    = "o_load_ack to fall";
		while (load_ack)
			next_cycle();
	endtask

	task automatic run_test(input int n);
		test_t tc;
		word_t want_ac;
		logic  want_link;
		string where;
		tc        = TESTS[n];
		where     = $sformatf("test %0d", n);
		want_ac   = tc.exp_ac;
		want_link = tc.exp_link;
		if (n == RAND_TEST)
			{want_link, want_ac} = {1'b0, rand_a} + {1'b0, rand_b};  // 13 bit add rule
		for (int i = 0; i < tc.count; i++)
			load_word(words[tc.first + i]);
		check_value(where, "o_run_ack", word_t'(0), word_t'(run_ack));  // Idle before request
		start_pc = tc.start_pc;
		sr       = tc.sr;
		run_req  = 1'b1;
		phase    = "o_run_ack to rise";
		while (!run_ack)
			next_cycle();
		check_value(where, "o_ac", want_ac, ac);
		check_value(where, "o_link", word_t'(want_link), word_t'(link));
		check_value(where, "o_pc", tc.exp_pc, pc);
		repeat (2) next_cycle();
		check_value(where, "o_run_ack", word_t'(1), word_t'(run_ack));  // Held with request
		run_req = 1'b0;
		next_cycle();
		check_value(where, "o_run_ack", word_t'(0), word_t'(run_ack));  // One cycle to drop
		phase = "o_run_ack to fall";
		while (run_ack)
			next_cycle();
	endtask

	// Run limit from the test lengths
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			errors++;
			$display("Timeout after %0d cycles, no response while waiting for %s", cycles, phase);
			$display("%0d checks, %0d errors", checks, errors);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		seed     = 32'h11e8_8ebc;
		errors   = 0;
		checks   = 0;
		cycles   = 0;
		phase    = "reset";
		rst_n    = 1'b0;
		load     = '0;
		load_req = 1'b0;
		run_req  = 1'b0;
		start_pc = '0;
		sr       = '0;
		for (int i = 0; i < NUM_WORDS; i++)
			words[i] = LOAD_TABLE[i];
		rand_a = word_t'($random(seed));
		rand_b = word_t'($random(seed));
		words[RAND_A_IDX].data = rand_a;                 // Page zero operand
		words[RAND_B_IDX].data = rand_b;                 // Current page operand
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		check_value("reset", "o_load_ack", word_t'(0), word_t'(load_ack));
		check_value("reset", "o_run_ack", word_t'(0), word_t'(run_ack));
		next_cycle();
		for (int n = 0; n < NUM_TESTS; n++)
			run_test(n);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: pdp8_top.f
+incdir+verification
logic/pdp8_pkg.sv
logic/pdp8_operate.sv
logic/pdp8_control.sv
logic/pdp8_memory.sv
logic/pdp8_top.sv
verification/pdp8_clock_gen.sv
verification/pdp8_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the PDP-8 testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module pdp8_tb -f pdp8_top.f -o pdp8_sim

./obj_dir/pdp8_sim | tee "$LOG"

if grep -q "^NO ERRORS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
